//--- bench/div_unit_asserts.sv
module div_unit_asserts
#(
    parameter int OPERAND_WIDTH = 16
)
(
    input logic                        clk_in,
    input logic                        reset_in,
    input logic                        pready,
    input logic                        req_valid,
    input logic                        req_ready,
    input logic [2*OPERAND_WIDTH+1:0]  req_data,
    input logic                        res_valid,
    input logic                        res_ready,
    input logic [2*OPERAND_WIDTH+1:0]  res_data,
    input div_types_pkg::div_stage_t   stage
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DIV_CYCLES = 3 * OPERAND_WIDTH;

    int fail_count = 0;

    // no wait states
    pready_high: assert property (@(posedge clk_in) disable iff (reset_in) pready)
    else
    begin
        $error("pready dropped low");
        fail_count++;
    end

    req_hold: assert property (@(posedge clk_in) disable iff (reset_in)
        req_valid && !req_ready |=> req_valid && $stable(req_data))
    else
    begin
        $error("request changed while waiting for ready");
        fail_count++;
    end

    res_hold: assert property (@(posedge clk_in) disable iff (reset_in)
        res_valid && !res_ready |=> res_valid && $stable(res_data))
    else
    begin
        $error("result changed while waiting for ready");
        fail_count++;
    end

    // accept edge, then three cycles per bit, then valid
    res_latency: assert property (@(posedge clk_in) disable iff (reset_in)
        req_valid && stage == div_types_pkg::STAGE_IDLE
        |=> !res_valid [*DIV_CYCLES] ##1 res_valid)
    else
    begin
        $error("result valid not seen 3*OPERAND_WIDTH+1 cycles after accept");
        fail_count++;
    end

endmodule

// fifo output side and divider result side
bind div_unit_top div_unit_asserts #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_asserts
(
    .clk_in    (clk_in),
    .reset_in  (reset_in),
    .pready    (pready),
    .req_valid (req_out_if.valid),
    .req_ready (req_out_if.ready),
    .req_data  ({req_out_if.dividend_sign, req_out_if.dividend,
                 req_out_if.divisor_sign, req_out_if.divisor}),
    .res_valid (res_if.valid),
    .res_ready (res_if.ready),
    .res_data  ({res_if.quotient_sign, res_if.quotient,
                 res_if.remainder_sign, res_if.remainder}),
    .stage     (u_divider.stage)
);

//--- bench/div_unit_checker.sv
module div_unit_checker
#(
    parameter int OPERAND_WIDTH = 16
)
(
    input logic                   clk_in,
    input logic                   reset_in,
    input logic                   psel,
    input logic                   penable,
    input logic                   pwrite,
    input apb_map_pkg::apb_addr_t paddr,
    input apb_map_pkg::apb_data_t prdata,
    input logic                   pslverr
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MODE_NONE   = 0;
    localparam int MODE_WORD   = 1;
    localparam int MODE_RESULT = 2;

    int                     mode = MODE_NONE;
    logic                   exp_err = 1'b0;
    apb_map_pkg::apb_data_t exp_word;
    apb_map_pkg::apb_data_t exp_quotient;
    apb_map_pkg::apb_data_t exp_remainder;
    int                     value_errors = 0;
    int                     response_errors = 0;

    // zero divisor gives all ones and the dividend back
    task automatic load_operands(input logic dsign, input logic [OPERAND_WIDTH-1:0] dividend,
                                 input logic vsign, input logic [OPERAND_WIDTH-1:0] divisor);
        logic [OPERAND_WIDTH-1:0] q_mag;
        logic [OPERAND_WIDTH-1:0] r_mag;
        if (divisor == 0)
        begin
            q_mag = '1;
            r_mag = dividend;
        end
        else
        begin
            q_mag = dividend / divisor;
            r_mag = dividend % divisor;
        end
        exp_quotient = '0;
        exp_quotient[31] = dsign ^ vsign;
        exp_quotient[OPERAND_WIDTH-1:0] = q_mag;
        exp_remainder = '0;
        exp_remainder[31] = dsign;
        exp_remainder[OPERAND_WIDTH-1:0] = r_mag;
        mode = MODE_RESULT;
    endtask

    task automatic expect_word(input apb_map_pkg::apb_data_t word);
        exp_word = word;
        mode = MODE_WORD;
    endtask

    task automatic expect_slverr(input logic err);
        exp_err = err;
    endtask

    function automatic string reg_name(input apb_map_pkg::apb_addr_t addr);
        case (addr)
            apb_map_pkg::REG_QUOTIENT:  return "REG_QUOTIENT";
            apb_map_pkg::REG_REMAINDER: return "REG_REMAINDER";
            apb_map_pkg::REG_STATUS:    return "REG_STATUS";
            default:                    return $sformatf("offset 0x%h", addr);
        endcase
    endfunction

    task automatic compare_word(input apb_map_pkg::apb_data_t expected);
        if (prdata !== expected)
        begin
            value_errors++;
            $display("ERR %s prdata expected 0x%h actual 0x%h at %0t",
                     reg_name(paddr), expected, prdata, $time);
        end
    endtask

    always @(posedge clk_in)
    begin
        if (!reset_in && psel && penable)
        begin
            if (pslverr !== exp_err)
            begin
                response_errors++;
                if (exp_err)
                    $display("missing pslverr on access to offset 0x%h at %0t", paddr, $time);
                else
                    $display("unexpected pslverr on access to offset 0x%h at %0t", paddr, $time);
            end
            exp_err = 1'b0;
            if (!pwrite)
            begin
                if (mode == MODE_WORD)
                begin
                    compare_word(exp_word);
                    mode = MODE_NONE;
                end
                else if (mode == MODE_RESULT && paddr == apb_map_pkg::REG_QUOTIENT)
                    compare_word(exp_quotient);
                else if (mode == MODE_RESULT && paddr == apb_map_pkg::REG_REMAINDER)
                    compare_word(exp_remainder);
                else if (paddr == apb_map_pkg::REG_STATUS && prdata[31:2] !== '0)
                begin
                    value_errors++;
                    $display("ERR REG_STATUS prdata[31:2] expected 0x%h actual 0x%h at %0t",
                             30'h0, prdata[31:2], $time);
                end
            end
        end
    end

    function automatic int error_total();
        return value_errors + response_errors;
    endfunction

    task automatic report(input int assert_fails);
        $display("checks done: %0d value errors, %0d response errors, %0d assertion failures",
                 value_errors, response_errors, assert_fails);
    endtask

endmodule

//--- bench/div_unit_tb.sv
module div_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OPERAND_WIDTH   = 16;
    localparam int FIFO_DEPTH      = 4;
    localparam int ROWS            = 20;
    localparam int WATCHDOG_CYCLES = (ROWS + 8) * (3 * OPERAND_WIDTH + 40);

    typedef struct packed
    {
        logic                     burst;
        logic                     dsign;
        logic [OPERAND_WIDTH-1:0] dividend;
        logic                     vsign;
        logic [OPERAND_WIDTH-1:0] divisor;
    } row_t;

    logic                   clk_in = 1'b0;
    logic                   reset_in;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    apb_map_pkg::apb_addr_t paddr;
    apb_map_pkg::apb_data_t pwdata;
    apb_map_pkg::apb_data_t prdata;
    logic                   pready;
    logic                   pslverr;

    integer seed = 32'hea2e0a94;
    row_t   rows [ROWS];
    row_t   pending [$];

    div_unit_top #(.OPERAND_WIDTH(OPERAND_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) uut
    (
        .clk_in(clk_in), .reset_in(reset_in), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr)
    );

    div_unit_checker #(.OPERAND_WIDTH(OPERAND_WIDTH)) chk
    (
        .clk_in(clk_in), .reset_in(reset_in), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .prdata(prdata), .pslverr(pslverr)
    );

    always #50 clk_in = ~clk_in;

    function automatic row_t make_row(input logic burst, input logic dsign, input int dividend,
                                      input logic vsign, input int divisor);
        return {burst, dsign, dividend[OPERAND_WIDTH-1:0], vsign, divisor[OPERAND_WIDTH-1:0]};
    endfunction

    function automatic apb_map_pkg::apb_data_t operand_word(input logic sign,
                                                            input logic [OPERAND_WIDTH-1:0] mag);
        return {sign, {(31 - OPERAND_WIDTH){1'b0}}, mag};
    endfunction

    // called on a falling edge, returns on the falling edge after the access phase
    task automatic apb_access(input logic write, input apb_map_pkg::apb_addr_t addr,
                              input apb_map_pkg::apb_data_t wdata,
                              output apb_map_pkg::apb_data_t rdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk_in);
        penable = 1'b1;
        @(posedge clk_in);
        rdata = prdata;
        @(negedge clk_in);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_map_pkg::apb_addr_t addr, input apb_map_pkg::apb_data_t data);
        apb_map_pkg::apb_data_t unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input apb_map_pkg::apb_addr_t addr);
        apb_map_pkg::apb_data_t status;
        apb_map_pkg::apb_data_t data;
        do
            apb_access(1'b0, apb_map_pkg::REG_STATUS, '0, status);
        while (!status[apb_map_pkg::STATUS_RESULT_BIT]);
        apb_access(1'b0, addr, '0, data);
    endtask

    task automatic send_request(input row_t row, input logic refused);
        apb_write(apb_map_pkg::REG_DIVIDEND, operand_word(row.dsign, row.dividend));
        if (refused)
            chk.expect_slverr(1'b1);
        apb_write(apb_map_pkg::REG_DIVISOR, operand_word(row.vsign, row.divisor));
    endtask

    task automatic read_result(input row_t row);
        chk.load_operands(row.dsign, row.dividend, row.vsign, row.divisor);
        apb_read(apb_map_pkg::REG_QUOTIENT);
        apb_read(apb_map_pkg::REG_REMAINDER);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("timeout: test did not end within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        logic [31:0]            r1;
        logic [31:0]            r2;
        int                     accepted;
        apb_map_pkg::apb_data_t rdata;
        reset_in = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        rows[0]  = make_row(0, 0, 100, 0, 7);
        rows[1]  = make_row(0, 0, 5, 0, 9);
        rows[2]  = make_row(0, 0, 1234, 0, 1);
        rows[3]  = make_row(0, 1, 100, 0, 7);
        rows[4]  = make_row(0, 0, 100, 1, 7);
        rows[5]  = make_row(0, 0, 4660, 0, 0);
        // burst group, the last one is refused
        rows[6]  = make_row(1, 1, 50000, 1, 13);
        rows[7]  = make_row(1, 0, 65535, 0, 255);
        rows[8]  = make_row(1, 1, 1, 0, 2);
        rows[9]  = make_row(1, 0, 0, 0, 3);
        rows[10] = make_row(1, 1, 777, 1, 0);
        rows[11] = make_row(1, 0, 300, 0, 17);
        for (int k = 12; k < ROWS; k++)
        begin
            r1 = $random(seed);
            r2 = $random(seed);
            rows[k] = make_row(0, r1[31], r1[15:0], r2[31], r2[15:0] >> r2[19:16]);
        end
        repeat (10) @(posedge clk_in);
        @(negedge clk_in);
        reset_in = 1'b0;
        chk.expect_word('0);
        apb_access(1'b0, apb_map_pkg::REG_STATUS, '0, rdata);
        chk.expect_slverr(1'b1);
        chk.expect_word('0);
        apb_access(1'b0, 8'h14, '0, rdata);
        chk.expect_word('0);
        apb_access(1'b0, apb_map_pkg::REG_QUOTIENT, '0, rdata);
        accepted = 0;
        for (int i = 0; i < ROWS; i++)
        begin
            if (!rows[i].burst)
            begin
                send_request(rows[i], 1'b0);
                read_result(rows[i]);
            end
            else
            begin
                // one request in the divider, FIFO_DEPTH more wait in the fifo
                if (accepted < FIFO_DEPTH + 1)
                begin
                    send_request(rows[i], 1'b0);
                    pending.push_back(rows[i]);
                    accepted++;
                end
                else
                begin
                    send_request(rows[i], 1'b1);
                end
                if (i == ROWS - 1 || !rows[i + 1].burst)
                begin
                    // divider still busy on the first one
                    chk.expect_word(32'h1 << apb_map_pkg::STATUS_FULL_BIT);
                    apb_access(1'b0, apb_map_pkg::REG_STATUS, '0, rdata);
                    while (pending.size() > 0)
                        read_result(pending.pop_front());
                    accepted = 0;
                end
            end
        end
        repeat (4) @(negedge clk_in);
        chk.report(uut.u_asserts.fail_count);
        if (chk.error_total() == 0 && uut.u_asserts.fail_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- div_unit.f
src/div_types_pkg.sv
src/apb_map_pkg.sv
src/div_ifs.sv
src/div_req_fifo.sv
src/multicycle_divider.sv
src/apb_div_regs.sv
src/div_unit_top.sv
bench/div_unit_asserts.sv
bench/div_unit_checker.sv
bench/div_unit_tb.sv

//--- src/apb_div_regs.sv
module apb_div_regs
#(
    parameter int OPERAND_WIDTH = 16
)
(
    input  logic                   clk_in,
    input  logic                   reset_in,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  apb_map_pkg::apb_addr_t paddr,
    input  apb_map_pkg::apb_data_t pwdata,
    output apb_map_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr,
    div_req_if.source              req,
    div_res_if.sink                res
);

    logic                     access;
    logic                     wr_access;
    logic                     rd_access;
    logic                     addr_mapped;
    logic                     divisor_write;
    logic                     divisor_reject;
    logic                     push_now;

    logic                     dividend_sign_q;
    logic [OPERAND_WIDTH-1:0] dividend_q;

    // single result slot
    logic                     slot_full;
    logic                     quotient_sign_q;
    logic [OPERAND_WIDTH-1:0] quotient_q;
    logic                     remainder_sign_q;
    logic [OPERAND_WIDTH-1:0] remainder_q;

    function automatic apb_map_pkg::apb_data_t pack_word
    (
        input logic                     sign,
        input logic [OPERAND_WIDTH-1:0] mag
    );
        apb_map_pkg::apb_data_t word;
        word = '0;
        word[apb_map_pkg::SIGN_BIT] = sign;
        word[OPERAND_WIDTH-1:0] = mag;
        return word;
    endfunction

    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign rd_access = access & ~pwrite;

    assign addr_mapped = paddr inside {apb_map_pkg::REG_DIVIDEND, apb_map_pkg::REG_DIVISOR,
                                       apb_map_pkg::REG_QUOTIENT, apb_map_pkg::REG_REMAINDER,
                                       apb_map_pkg::REG_STATUS};

    assign divisor_write  = wr_access & (paddr == apb_map_pkg::REG_DIVISOR);
    assign push_now       = divisor_write & req.ready;
    // fifo full, request is dropped
    assign divisor_reject = divisor_write & ~req.ready;

    assign pready  = 1'b1;
    assign pslverr = access & (~addr_mapped | divisor_reject);

    assign res.ready = ~slot_full;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            req.valid <= 1'b0;
        end
        else
        begin
            req.valid <= push_now;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (wr_access && paddr == apb_map_pkg::REG_DIVIDEND)
        begin
            dividend_sign_q <= pwdata[apb_map_pkg::SIGN_BIT];
            dividend_q      <= pwdata[OPERAND_WIDTH-1:0];
        end
        if (push_now)
        begin
            req.dividend_sign <= dividend_sign_q;
            req.dividend      <= dividend_q;
            req.divisor_sign  <= pwdata[apb_map_pkg::SIGN_BIT];
            req.divisor       <= pwdata[OPERAND_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            slot_full <= 1'b0;
        end
        else if (res.valid && res.ready)
        begin
            slot_full <= 1'b1;
        end
        else if (rd_access && paddr == apb_map_pkg::REG_REMAINDER)
        begin
            slot_full <= 1'b0;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (res.valid && res.ready)
        begin
            quotient_sign_q  <= res.quotient_sign;
            quotient_q       <= res.quotient;
            remainder_sign_q <= res.remainder_sign;
            remainder_q      <= res.remainder;
        end
    end

    // read mux, zero outside a read access
    always_comb
    begin
        prdata = '0;
        if (rd_access)
        begin
            case (paddr)
                apb_map_pkg::REG_DIVIDEND:
                begin
                    prdata = pack_word(dividend_sign_q, dividend_q);
                end
                apb_map_pkg::REG_DIVISOR:
                begin
                    prdata = pack_word(req.divisor_sign, req.divisor);
                end
                apb_map_pkg::REG_QUOTIENT:
                begin
                    if (slot_full)
                    begin
                        prdata = pack_word(quotient_sign_q, quotient_q);
                    end
                end
                apb_map_pkg::REG_REMAINDER:
                begin
                    if (slot_full)
                    begin
                        prdata = pack_word(remainder_sign_q, remainder_q);
                    end
                end
                apb_map_pkg::REG_STATUS:
                begin
                    prdata[apb_map_pkg::STATUS_RESULT_BIT] = slot_full;
                    prdata[apb_map_pkg::STATUS_FULL_BIT]   = ~req.ready;
                end
                default:
                begin
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

//--- src/apb_map_pkg.sv
package apb_map_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // byte offsets
    localparam apb_addr_t REG_DIVIDEND  = 8'h00;
    localparam apb_addr_t REG_DIVISOR   = 8'h04;
    localparam apb_addr_t REG_QUOTIENT  = 8'h08;
    localparam apb_addr_t REG_REMAINDER = 8'h0C;
    localparam apb_addr_t REG_STATUS    = 8'h10;

    // operand words carry the sign here, magnitude sits at the bottom
    localparam int SIGN_BIT = 31;

    // status register bits
    localparam int STATUS_RESULT_BIT = 0;
    localparam int STATUS_FULL_BIT   = 1;

endpackage

//--- src/div_ifs.sv
interface div_req_if
#(
    parameter int OPERAND_WIDTH = 16
);
    logic                     valid;
    logic                     ready;
    logic                     dividend_sign;
    logic [OPERAND_WIDTH-1:0] dividend;
    logic                     divisor_sign;
    logic [OPERAND_WIDTH-1:0] divisor;

    modport source
    (
        output valid, dividend_sign, dividend, divisor_sign, divisor,
        input  ready
    );

    modport sink
    (
        input  valid, dividend_sign, dividend, divisor_sign, divisor,
        output ready
    );

    modport monitor
    (
        input valid, ready, dividend_sign, dividend, divisor_sign, divisor
    );
endinterface

interface div_res_if
#(
    parameter int OPERAND_WIDTH = 16
);
    logic                     valid;
    logic                     ready;
    logic                     quotient_sign;
    logic [OPERAND_WIDTH-1:0] quotient;
    logic                     remainder_sign;
    logic [OPERAND_WIDTH-1:0] remainder;

    modport source
    (
        output valid, quotient_sign, quotient, remainder_sign, remainder,
        input  ready
    );

    modport sink
    (
        input  valid, quotient_sign, quotient, remainder_sign, remainder,
        output ready
    );

    modport monitor
    (
        input valid, ready, quotient_sign, quotient, remainder_sign, remainder
    );
endinterface

//--- src/div_req_fifo.sv
module div_req_fifo
#(
    parameter int OPERAND_WIDTH = 16,
    parameter int FIFO_DEPTH    = 4
)
(
    input logic        clk_in,
    input logic        reset_in,
    div_req_if.sink    wr,
    div_req_if.source  rd
);

    localparam int ENTRY_W = 2 * OPERAND_WIDTH + 2;
    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int CNT_W   = PTR_W + 1;

    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(FIFO_DEPTH);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [ENTRY_W-1:0] head_entry;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    assign wr.ready = (count != FULL_COUNT);
    assign rd.valid = (count != '0);

    assign push = wr.valid & wr.ready;
    assign pop  = rd.valid & rd.ready;

    // packed as dividend sign, dividend, divisor sign, divisor
    assign head_entry = mem[rd_ptr];
    assign {rd.dividend_sign, rd.dividend, rd.divisor_sign, rd.divisor} = head_entry;

    always_ff @(posedge clk_in)
    begin
        if (push)
        begin
            mem[wr_ptr] <= {wr.dividend_sign, wr.dividend, wr.divisor_sign, wr.divisor};
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

//--- src/div_types_pkg.sv
package div_types_pkg;

    // one bit takes shift, sub and test
    typedef enum logic [2:0]
    {
        STAGE_IDLE,
        STAGE_SHIFT,
        STAGE_SUB,
        STAGE_TEST,
        STAGE_DONE
    } div_stage_t;

    // enough for operands up to 32 bits
    localparam int BIT_CNT_WIDTH = 6;

endpackage

//--- src/div_unit_top.sv
module div_unit_top
#(
    parameter int OPERAND_WIDTH = 16,
    parameter int FIFO_DEPTH    = 4
)
(
    input  logic                   clk_in,
    input  logic                   reset_in,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  apb_map_pkg::apb_addr_t paddr,
    input  apb_map_pkg::apb_data_t pwdata,
    output apb_map_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr
);

    // register block to fifo
    div_req_if #(.OPERAND_WIDTH(OPERAND_WIDTH)) req_in_if ();
    // fifo to divider
    div_req_if #(.OPERAND_WIDTH(OPERAND_WIDTH)) req_out_if ();
    // divider back to register block
    div_res_if #(.OPERAND_WIDTH(OPERAND_WIDTH)) res_if ();

    apb_div_regs #(
        .OPERAND_WIDTH (OPERAND_WIDTH)
    ) u_regs (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .req      (req_in_if.source),
        .res      (res_if.sink)
    );

    div_req_fifo #(
        .OPERAND_WIDTH (OPERAND_WIDTH),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_fifo (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .wr       (req_in_if.sink),
        .rd       (req_out_if.source)
    );

    multicycle_divider #(
        .OPERAND_WIDTH (OPERAND_WIDTH)
    ) u_divider (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .req      (req_out_if.sink),
        .res      (res_if.source)
    );

endmodule

//--- src/multicycle_divider.sv
module multicycle_divider
#(
    parameter int OPERAND_WIDTH = 16
)
(
    input logic        clk_in,
    input logic        reset_in,
    div_req_if.sink    req,
    div_res_if.source  res
);

    localparam int CNT_W = div_types_pkg::BIT_CNT_WIDTH;

    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(OPERAND_WIDTH - 1);

    div_types_pkg::div_stage_t stage;

    logic [CNT_W-1:0]           bit_cnt;

    // partial remainder on top (one guard bit), quotient below
    logic [2*OPERAND_WIDTH:0]   rq;
    logic [OPERAND_WIDTH-1:0]   divisor_q;
    logic [OPERAND_WIDTH+1:0]   diff_q;
    logic                       dividend_sign_q;
    logic                       divisor_sign_q;
    logic                       diff_negative;

    assign diff_negative = diff_q[OPERAND_WIDTH+1];

    assign req.ready = (stage == div_types_pkg::STAGE_IDLE);

    assign res.valid          = (stage == div_types_pkg::STAGE_DONE);
    assign res.quotient       = rq[OPERAND_WIDTH-1:0];
    assign res.remainder      = rq[2*OPERAND_WIDTH-1:OPERAND_WIDTH];
    // truncated division signs
    assign res.quotient_sign  = dividend_sign_q ^ divisor_sign_q;
    assign res.remainder_sign = dividend_sign_q;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            stage   <= div_types_pkg::STAGE_IDLE;
            bit_cnt <= '0;
        end
        else
        begin
            case (stage)
                div_types_pkg::STAGE_IDLE:
                begin
                    bit_cnt <= '0;
                    if (req.valid)
                    begin
                        stage <= div_types_pkg::STAGE_SHIFT;
                    end
                end
                div_types_pkg::STAGE_SHIFT:
                begin
                    stage <= div_types_pkg::STAGE_SUB;
                end
                div_types_pkg::STAGE_SUB:
                begin
                    stage <= div_types_pkg::STAGE_TEST;
                end
                div_types_pkg::STAGE_TEST:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == LAST_BIT)
                    begin
                        stage <= div_types_pkg::STAGE_DONE;
                    end
                    else
                    begin
                        stage <= div_types_pkg::STAGE_SHIFT;
                    end
                end
                div_types_pkg::STAGE_DONE:
                begin
                    // wait here until the result is taken
                    if (res.ready)
                    begin
                        stage <= div_types_pkg::STAGE_IDLE;
                    end
                end
                default:
                begin
                    stage <= div_types_pkg::STAGE_IDLE;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_in)
    begin
        case (stage)
            div_types_pkg::STAGE_IDLE:
            begin
                if (req.valid)
                begin
                    rq              <= {{(OPERAND_WIDTH + 1){1'b0}}, req.dividend};
                    divisor_q       <= req.divisor;
                    dividend_sign_q <= req.dividend_sign;
                    divisor_sign_q  <= req.divisor_sign;
                end
            end
            div_types_pkg::STAGE_SHIFT:
            begin
                rq <= rq << 1;
            end
            div_types_pkg::STAGE_SUB:
            begin
                diff_q <= {1'b0, rq[2*OPERAND_WIDTH:OPERAND_WIDTH]} - {2'b00, divisor_q};
            end
            div_types_pkg::STAGE_TEST:
            begin
                if (!diff_negative)
                begin
                    rq[2*OPERAND_WIDTH:OPERAND_WIDTH] <= diff_q[OPERAND_WIDTH:0];
                end
                rq[0] <= ~diff_negative;
            end
            default:
            begin
            end
        endcase
    end

endmodule
